//--- common/ecc_pkg.sv
`default_nettype none

// shared widths and types for the SEC-DED protected word store
package ecc_pkg;

   // data word and check field
   localparam int data_w  = 32;
   localparam int check_w = 7;                  // six hamming bits + overall parity
   localparam int code_w  = data_w + check_w;   // 39

   // store geometry
   localparam int mem_depth = 8;
   localparam int addr_w    = 3;

   // error counters
   localparam int cnt_w = 8;

   typedef logic [data_w-1:0]  data_t;
   typedef logic [check_w-1:0] check_t;
   typedef logic [addr_w-1:0]  addr_t;
   typedef logic [cnt_w-1:0]   cnt_t;

   // stored layout is {check, data}
   // so mask bit i hits data bit i below 32, check bit i-32 above
   typedef logic [code_w-1:0]  codeword_t;

   localparam cnt_t cnt_max = '1;   // counters saturate here

endpackage

`default_nettype wire

//--- ecc/ecc_encode.sv
`default_nettype none

module ecc_encode import ecc_pkg::*; (
   input  data_t  data,
   output check_t check
);

   logic [check_w-2:0] ham;   // six hamming bits

   // each hamming bit covers the data bits whose codeword position
   // has the matching bit set
   assign ham[0] = data[0]  ^ data[1]  ^ data[3]  ^ data[4]  ^ data[6]  ^
                   data[8]  ^ data[10] ^ data[11] ^ data[13] ^ data[15] ^
                   data[17] ^ data[19] ^ data[21] ^ data[23] ^ data[25] ^
                   data[26] ^ data[28] ^ data[30];

   assign ham[1] = data[0]  ^ data[2]  ^ data[3]  ^ data[5]  ^ data[6]  ^
                   data[9]  ^ data[10] ^ data[12] ^ data[13] ^ data[16] ^
                   data[17] ^ data[20] ^ data[21] ^ data[24] ^ data[25] ^
                   data[27] ^ data[28] ^ data[31];

   assign ham[2] = data[1]  ^ data[2]  ^ data[3]  ^ data[7]  ^ data[8]  ^
                   data[9]  ^ data[10] ^ data[14] ^ data[15] ^ data[16] ^
                   data[17] ^ data[22] ^ data[23] ^ data[24] ^ data[25] ^
                   data[29] ^ data[30] ^ data[31];

   // upper bits cover contiguous runs
   assign ham[3] = (^data[10:4]) ^ (^data[25:18]);
   assign ham[4] = ^data[25:11];
   assign ham[5] = ^data[31:26];

   // overall parity over data and hamming bits, makes the code SEC-DED
   assign check = {(^data) ^ (^ham), ham};

endmodule

`default_nettype wire

//--- ecc/ecc_decode.sv
`default_nettype none

module ecc_decode import ecc_pkg::*; (
   input  codeword_t code,
   input  logic      sed_ded,      // detect only, no correction
   output data_t     data,
   output logic      single_err,
   output logic      double_err
);

   data_t               rx_data;
   check_t              rx_check;
   logic [code_w-1:0]   expanded;   // hamming order, index i is position i+1
   logic [code_w-1:0]   err_mask;
   logic [code_w-1:0]   fixed;
   logic [check_w-2:0]  syndrome;
   logic                par_raw;
   logic                par_err;

   assign rx_data  = code[data_w-1:0];
   assign rx_check = code[code_w-1:data_w];

   // interleave check bits at the power-of-two positions,
   // overall parity sits on top at position 39
   assign expanded = {rx_check[6], rx_data[31:26],
                      rx_check[5], rx_data[25:11],
                      rx_check[4], rx_data[10:4],
                      rx_check[3], rx_data[3:1],
                      rx_check[2], rx_data[0],
                      rx_check[1:0]};

   // syndrome is the xor of the positions of all set bits,
   // which equals stored check xor recomputed check
   always_comb begin
      syndrome = '0;
      for (int i = 0; i < code_w - 1; i++) begin
         if (expanded[i]) begin
            syndrome ^= (check_w-1)'(i + 1);
         end
      end
   end

   assign par_raw = ^code;                  // even over all 39 bits when clean
   assign par_err = par_raw & ~sed_ded;     // detect-only drops the parity term

   // odd number of flips -> correctable single, even and nonzero -> double
   assign single_err = par_err;                       // also covers a hit on the parity bit
   assign double_err = (syndrome != '0) & ~par_err;   // every error lands here in sed_ded mode

   // one-hot pointer at the failing position
   always_comb begin
      for (int i = 0; i < code_w; i++) begin
         err_mask[i] = (syndrome == (check_w-1)'(i + 1));
      end
   end

   assign fixed = single_err ? (expanded ^ err_mask) : expanded;

   // check-bit hits are dropped here, data passes unchanged
   assign data = {fixed[37:32], fixed[30:16], fixed[14:8], fixed[6:4], fixed[2]};

endmodule

`default_nettype wire

//--- hw/ecc_word_store.sv
`default_nettype none

module ecc_word_store import ecc_pkg::*; (
   input  logic      clk,
   input  logic      rst_l,
   input  logic      wr_en,
   input  addr_t     wr_addr,
   input  codeword_t wr_code,
   input  codeword_t inj_mask,
   input  logic      rd_en,
   input  addr_t     rd_addr,
   output codeword_t rd_code,
   output logic      rd_code_valid
);

   codeword_t mem [mem_depth];

   // all-zero is a legal codeword, so a cleared entry reads back as clean 0
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         for (int i = 0; i < mem_depth; i++) begin
            mem[i] <= '0;
         end
      end else if (wr_en) begin
         mem[wr_addr] <= wr_code ^ inj_mask;   // fault injection on the way in
      end
   end

   // registered read port, sees the old word on a same-address write
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_code <= mem[rd_addr];
      end
   end

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         rd_code_valid <= 1'b0;
      end else begin
         rd_code_valid <= rd_en;
      end
   end

endmodule

`default_nettype wire

//--- hw/ecc_read_path.sv
`default_nettype none

module ecc_read_path import ecc_pkg::*; (
   input  logic      clk,
   input  logic      rst_l,
   input  codeword_t code,
   input  logic      code_valid,
   input  logic      sed_ded,
   output logic      rd_valid,
   output data_t     rd_data,
   output logic      single_err,
   output logic      double_err,
   output cnt_t      single_count,
   output cnt_t      double_count
);

   data_t dec_data;
   logic  dec_single;
   logic  dec_double;
   logic  single_hit;
   logic  double_hit;

   ecc_decode i_decode (
      .code       (code),
      .sed_ded    (sed_ded),
      .data       (dec_data),
      .single_err (dec_single),
      .double_err (dec_double)
   );

   // flags only count for a real read in the decode stage
   assign single_hit = code_valid & dec_single;
   assign double_hit = code_valid & dec_double;

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         rd_valid   <= 1'b0;
         single_err <= 1'b0;
         double_err <= 1'b0;
      end else begin
         rd_valid   <= code_valid;
         single_err <= single_hit;
         double_err <= double_hit;
      end
   end

   always_ff @(posedge clk) begin
      if (code_valid) begin
         rd_data <= dec_data;   // corrected word
      end
   end

   // saturating error counters, same edge as the flags
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         single_count <= '0;
         double_count <= '0;
      end else begin
         if (single_hit && single_count != cnt_max) single_count <= single_count + 1'b1;
         if (double_hit && double_count != cnt_max) double_count <= double_count + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- hw/ecc_mem_top.sv
`default_nettype none

module ecc_mem_top import ecc_pkg::*; (
   input  logic      clk,
   input  logic      rst_l,
   input  logic      wr_en,
   input  addr_t     wr_addr,
   input  data_t     wr_data,
   input  codeword_t inj_mask,
   input  logic      rd_en,
   input  addr_t     rd_addr,
   input  logic      sed_ded,
   output logic      rd_valid,
   output data_t     rd_data,
   output logic      single_err,
   output logic      double_err,
   output cnt_t      single_count,
   output cnt_t      double_count
);

   check_t    wr_check;
   codeword_t wr_code;
   codeword_t rd_code;
   logic      rd_code_valid;

   ecc_encode i_encode (
      .data  (wr_data),
      .check (wr_check)
   );

   assign wr_code = {wr_check, wr_data};   // check bits on top

   ecc_word_store i_store (
      .clk           (clk),
      .rst_l         (rst_l),
      .wr_en         (wr_en),
      .wr_addr       (wr_addr),
      .wr_code       (wr_code),
      .inj_mask      (inj_mask),
      .rd_en         (rd_en),
      .rd_addr       (rd_addr),
      .rd_code       (rd_code),
      .rd_code_valid (rd_code_valid)
   );

   ecc_read_path i_read_path (
      .clk          (clk),
      .rst_l        (rst_l),
      .code         (rd_code),
      .code_valid   (rd_code_valid),
      .sed_ded      (sed_ded),
      .rd_valid     (rd_valid),
      .rd_data      (rd_data),
      .single_err   (single_err),
      .double_err   (double_err),
      .single_count (single_count),
      .double_count (double_count)
   );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`default_nettype none

module tb_clock (
   output logic clk,
   output logic rst_l
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;   // 100 ns period
   end

   // reset held low for the first 4 rising edges
   initial begin
      rst_l <= 1'b0;
      repeat (4) @(posedge clk);
      rst_l <= 1'b1;
   end

endmodule

`default_nettype wire

//--- bench/ecc_mem_assertions.sv
`default_nettype none

module ecc_mem_assertions (
   input logic clk,
   input logic rst_l,
   input logic rd_en,
   input logic rd_valid,
   input logic single_err,
   input logic double_err
);
   timeunit 1ns;
   timeprecision 100ps;

   int fail_count = 0;   // failures so far, watched by the testbench

   // store stage then decode stage, so exactly two edges
   valid_two_after_en: assert property (
      @(posedge clk) disable iff (!rst_l) rd_valid == $past(rd_en, 2)
   ) else begin
      fail_count++;
      $error("rd_valid does not follow rd_en by two cycles");
   end

   flags_need_valid: assert property (
      @(posedge clk) disable iff (!rst_l) (single_err || double_err) |-> rd_valid
   ) else begin
      fail_count++;
      $error("error flag high without rd_valid");
   end

   // a read is either correctable or not, never both
   one_flag_only: assert property (
      @(posedge clk) disable iff (!rst_l) !(single_err && double_err)
   ) else begin
      fail_count++;
      $error("single_err and double_err high together");
   end

endmodule

bind ecc_mem_top ecc_mem_assertions i_assertions (
   .clk        (clk),
   .rst_l      (rst_l),
   .rd_en      (rd_en),
   .rd_valid   (rd_valid),
   .single_err (single_err),
   .double_err (double_err)
);

`default_nettype wire

//--- bench/tb_ecc_mem.sv
`default_nettype none

module tb_ecc_mem import ecc_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   // record: test op addr sed data mask single double single_count double_count
   localparam int rec_w     = 112;
   localparam int max_lines = 64;

   logic      clk;
   logic      rst_l;
   logic      wr_en;
   addr_t     wr_addr;
   data_t     wr_data;
   codeword_t inj_mask;
   logic      rd_en;
   addr_t     rd_addr;
   logic      sed_ded;
   logic      rd_valid;
   data_t     rd_data;
   logic      single_err;
   logic      double_err;
   cnt_t      single_count;
   cnt_t      double_count;

   logic [rec_w-1:0] stim [max_lines];
   logic [rec_w-1:0] exp_q [$];           // pending reads, oldest first
   int               due_q [$];           // cycle in which each result is due
   int               cycles      = 0;
   int               cycle_limit = 1000;  // replaced once the file is read
   int               n_reads     = 0;
   int               n_checked   = 0;

   tb_clock i_clock (
      .clk   (clk),
      .rst_l (rst_l)
   );

   ecc_mem_top i_dut (
      .clk          (clk),
      .rst_l        (rst_l),
      .wr_en        (wr_en),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .inj_mask     (inj_mask),
      .rd_en        (rd_en),
      .rd_addr      (rd_addr),
      .sed_ded      (sed_ded),
      .rd_valid     (rd_valid),
      .rd_data      (rd_data),
      .single_err   (single_err),
      .double_err   (double_err),
      .single_count (single_count),
      .double_count (double_count)
   );

   task automatic stop_on_failure();
      $display("Checks failed");
      $fatal(1, "stopped at first failure");
   endtask

   task automatic compare_value(input string test, input string field,
                                input logic [39:0] exp_val, input logic [39:0] act_val);
      assert (act_val === exp_val) else begin
         $display("ERR %s %s expected %0h actual %0h", test, field, exp_val, act_val);
         stop_on_failure();
      end
   endtask

   function automatic string behavior_name(input logic [3:0] id);
      case (id)
         4'd1: return "clean_read";
         4'd2: return "single_data_error";
         4'd3: return "check_bit_error";
         4'd4: return "double_error";
         4'd5: return "detect_only";
         4'd6: return "back_to_back";
         default: return "unknown";
      endcase
   endfunction

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout after %0d cycles, results still outstanding", cycles);
         stop_on_failure();
      end
   end

   initial begin
      logic [rec_w-1:0] rec;
      logic [3:0]       op;
      logic             delayed_sed;
      int               n_lines;

      wr_en    <= 1'b0;
      wr_addr  <= '0;
      wr_data  <= '0;
      inj_mask <= '0;
      rd_en    <= 1'b0;
      rd_addr  <= '0;
      sed_ded  <= 1'b0;
      delayed_sed = 1'b0;

      $readmemh("bench/ecc_stimulus.txt", stim);
      n_lines = 0;
      while (n_lines < max_lines && stim[n_lines][107:104] !== 4'hf) begin
         n_lines++;
      end
      if (n_lines == max_lines) begin
         $display("stimulus file has no end record");
         stop_on_failure();
      end
      cycle_limit = 4 * n_lines + 20;

      while (rst_l !== 1'b1) @(posedge clk);

      for (int i = 0; i < n_lines; i++) begin
         rec = stim[i];
         op  = rec[107:104];
         wr_en    <= (op == 4'h1);
         wr_addr  <= rec[102:100];
         wr_data  <= (op == 4'h1) ? rec[95:64] : '0;
         inj_mask <= (op == 4'h1) ? rec[62:24] : '0;
         rd_en    <= (op == 4'h2);
         rd_addr  <= rec[102:100];
         sed_ded  <= delayed_sed;   // sed_ded belongs to the decode cycle
         delayed_sed = (op == 4'h2) && rec[96];
         if (op == 4'h2) begin
            exp_q.push_back(rec);
            due_q.push_back(cycles + 3);
            n_reads++;
         end
         @(posedge clk);
      end

      wr_en    <= 1'b0;
      rd_en    <= 1'b0;
      inj_mask <= '0;
      sed_ded  <= delayed_sed;
      @(posedge clk);
      sed_ded  <= 1'b0;
      while (exp_q.size() != 0) @(posedge clk);
      repeat (3) @(posedge clk);   // room for a stray rd_valid

      if (n_checked == n_reads) begin
         $display("All checks passed");
         $finish;
      end else begin
         $display("%0d reads issued but %0d results seen", n_reads, n_checked);
         stop_on_failure();
      end
   end

   // outputs settle after the rising edge, so look at them on the falling one
   always @(negedge clk) begin
      logic [rec_w-1:0] exp_rec;
      int               due;
      string            name;

      if (i_dut.i_assertions.fail_count != 0) begin
         $display("a protocol assertion on the DUT outputs failed");
         stop_on_failure();
      end

      if (rst_l === 1'b1) begin
         if (rd_valid !== 1'b1) begin
            if (due_q.size() != 0 && due_q[0] <= cycles) begin
               $display("no rd_valid for the read due in cycle %0d", due_q[0]);
               stop_on_failure();
            end
            compare_value("idle", "single_err", 40'h0, 40'(single_err));
            compare_value("idle", "double_err", 40'h0, 40'(double_err));
         end else if (exp_q.size() == 0) begin
            $display("rd_valid high with no read pending");
            stop_on_failure();
         end else begin
            exp_rec = exp_q.pop_front();
            due     = due_q.pop_front();
            name    = behavior_name(exp_rec[111:108]);
            compare_value(name, "latency", 40'(due), 40'(cycles));
            compare_value(name, "rd_data", 40'(exp_rec[95:64]), 40'(rd_data));
            compare_value(name, "single_err", 40'(exp_rec[20]), 40'(single_err));
            compare_value(name, "double_err", 40'(exp_rec[16]), 40'(double_err));
            compare_value(name, "single_count", 40'(exp_rec[15:8]), 40'(single_count));
            compare_value(name, "double_count", 40'(exp_rec[7:0]), 40'(double_count));
            n_checked++;
         end
      end
   end

endmodule

`default_nettype wire

//--- bench/ecc_stimulus.txt
// test_op_addr_sed_data_mask_single_double_scount_dcount, op 1 write 2 read f end
// write lines use data and mask, read lines give expected data, flags and counts
1_2_7_0_00000000_0000000000_0_0_00_00
1_1_0_0_DEADBEEF_0000000000_0_0_00_00
1_2_0_0_DEADBEEF_0000000000_0_0_00_00
2_1_1_0_12345678_0000000020_0_0_00_00
2_2_1_0_12345678_0000000000_1_0_01_00
3_1_2_0_A5A5A5A5_0400000000_0_0_00_00
3_2_2_0_A5A5A5A5_0000000000_1_0_02_00
3_1_3_0_0F0F0F0F_4000000000_0_0_00_00
3_2_3_0_0F0F0F0F_0000000000_1_0_03_00
4_1_4_0_CAFEF00D_0080000001_0_0_00_00
4_2_4_0_4AFEF00C_0000000000_0_1_03_01
4_1_6_0_55555555_0200000004_0_0_00_00
4_2_6_0_55555551_0000000000_0_1_03_02
5_1_5_0_00FF00FF_0000010000_0_0_00_00
5_2_5_1_00FE00FF_0000000000_0_1_03_03
6_2_0_0_DEADBEEF_0000000000_0_0_03_03
6_2_1_0_12345678_0000000000_1_0_04_03
6_2_5_1_00FE00FF_0000000000_0_1_04_04
6_2_4_0_4AFEF00C_0000000000_0_1_04_05
6_2_2_0_A5A5A5A5_0000000000_1_0_05_05
6_2_0_1_DEADBEEF_0000000000_0_0_05_05
6_2_6_1_55555551_0000000000_0_1_05_06
0_f_0_0_00000000_0000000000_0_0_00_00

//--- compile.f
common/ecc_pkg.sv
ecc/ecc_encode.sv
ecc/ecc_decode.sv
hw/ecc_word_store.sv
hw/ecc_read_path.sv
hw/ecc_mem_top.sv
bench/tb_clock.sv
bench/ecc_mem_assertions.sv
bench/tb_ecc_mem.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       ?= tb_ecc_mem
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Checks failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test FAILED"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "test FAILED, no result"; exit 1; fi
	@echo "test PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
